// File: run_sim.sh
#!/bin/sh
# build the local_move testbench with Verilator, run it, judge the run from sim.log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module local_move_tb \
    -f sources.f -Mdir obj_dir -o local_move_sim \
    && ./obj_dir/local_move_sim > sim.log 2>&1 \
    || echo "SIMULATION FAILED" >> sim.log
cat sim.log
grep -q "SIMULATION FAILED" sim.log && exit 1 || exit 0

// File: sources.f
verilog/sat_pkg.sv
verilog/clause_store.sv
verilog/clause_eval.sv
verilog/move_proposer.sv
verilog/best_move_select.sv
verilog/local_move.sv
test/local_move_tb.sv

// File: test/local_move_tb.sv
`default_nettype none

module local_move_tb
    import sat_pkg::*;
();

    localparam int    max_entries = 64;   // data lines the table can hold
    localparam int    num_fields  = 14;   // widest line, a search
    localparam int    done_slack  = 6;    // extra cycles before done counts as missing
    localparam string test_file   = "test/local_move_tests.txt";

    //////////////////////////////////////////////////
    // DUT signals

    logic                     clk;
    logic                     rst_n;
    logic                     clause_write;
    logic [1:0]               clause_index;
    clause_t                  clause_data;
    logic [num_clauses-1:0]   clause_enable;
    assign_t                  current;
    logic [num_bool_vars-1:0] bool_propose_enable;
    logic [num_int_vars-1:0]  int_propose_enable;
    logic                     start;
    gain_t [num_vars-1:0]     gains;
    gain_t                    best_gain;
    assign_t                  best_assignment;
    logic                     done;

    // test table, one row per data line of the file
    int  n_entries;
    byte kind [max_entries];              // W write, S search, C search chained to the previous
    int  fld  [max_entries][num_fields];
    bit  loaded;                          // table ready, watchdog may start

    int checks;
    int value_errors;
    int protocol_errors;                  // done missing, early or late
    int file_errors;

    local_move dut0 (
        .clk                 (clk),
        .rst_n               (rst_n),
        .clause_write        (clause_write),
        .clause_index        (clause_index),
        .clause_data         (clause_data),
        .clause_enable       (clause_enable),
        .current             (current),
        .bool_propose_enable (bool_propose_enable),
        .int_propose_enable  (int_propose_enable),
        .start               (start),
        .gains               (gains),
        .best_gain           (best_gain),
        .best_assignment     (best_assignment),
        .done                (done)
    );

    always #10 clk = ~clk;  // period 20

    //////////////////////////////////////////////////
    // file loading

    task automatic load_tests();
        int    fd;
        int    rc;
        string line;
        string body;
        byte   tag;
        fd = $fopen(test_file, "r");
        if (fd == 0)
        begin
            file_errors++;
            $display("cannot open the test file %s", test_file);
        end
        else
        begin
            while ($fgets(line, fd) > 0)
            begin
                tag = line.getc(0);
                if (tag == "W" || tag == "S" || tag == "C")
                begin
                    if (n_entries >= max_entries)
                    begin
                        file_errors++;
                        $display("test file has more than %0d data lines", max_entries);
                        break;
                    end
                    body = line.substr(1, line.len() - 1);
                    kind[n_entries] = tag;
                    if (tag == "W")
                    begin
                        rc = $sscanf(body, "%h %h %h %h %h %h", fld[n_entries][0],
                                     fld[n_entries][1], fld[n_entries][2], fld[n_entries][3],
                                     fld[n_entries][4], fld[n_entries][5]);
                        rc = (rc == 6) ? num_fields : rc;  // write lines carry six fields
                    end
                    else
                    begin
                        rc = $sscanf(body, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                                     fld[n_entries][0], fld[n_entries][1], fld[n_entries][2],
                                     fld[n_entries][3], fld[n_entries][4], fld[n_entries][5],
                                     fld[n_entries][6], fld[n_entries][7], fld[n_entries][8],
                                     fld[n_entries][9], fld[n_entries][10], fld[n_entries][11],
                                     fld[n_entries][12], fld[n_entries][13]);
                    end
                    if (rc != num_fields)
                    begin
                        file_errors++;
                        $display("data line %0d of the test file is malformed", n_entries);
                    end
                    n_entries++;
                end
                else if (tag != "#" && tag != "\n" && tag != " " && tag != "\r")
                begin
                    file_errors++;
                    $display("unknown line type in the test file: %s", line);
                end
            end
            $fclose(fd);
            if (n_entries == 0)
            begin
                file_errors++;
                $display("the test file holds no data lines");
            end
        end
    endtask

    //////////////////////////////////////////////////
    // checks

    task automatic check_value(input string name, input logic [15:0] expected,
                               input logic [15:0] actual);
        checks++;
        assert (actual === expected)
        else
        begin
            value_errors++;
            $display("** Error: %s expected %0h actual %0h", name, expected, actual);
        end
    endtask

    // compare one search's outputs with its row
    task automatic check_results(input int n);
        assign_t exp_a;
        exp_a.bool_val = fld[n][11][1:0];
        exp_a.int_val1 = fld[n][12][3:0];
        exp_a.int_val0 = fld[n][13][3:0];
        for (int i = 0; i < num_vars; i++)
        begin
            check_value($sformatf("gains[%0d]", i), 16'(fld[n][6+i]), 16'(gains[i]));
        end
        check_value("best_gain", 16'(fld[n][10]), 16'(best_gain));
        check_value("best_assignment", {6'd0, exp_a}, {6'd0, best_assignment});
    endtask

    // quiet period after reset, nothing may move
    task automatic check_idle(input int cycles);
        repeat (cycles)
        begin
            @(negedge clk);
            checks++;
            assert (done == 1'b0)
            else
            begin
                protocol_errors++;
                $display("done pulsed after reset with no search started");
            end
        end
        check_value("gains", 16'd0, 16'(gains));
        check_value("best_gain", 16'd0, 16'(best_gain));
        check_value("best_assignment", 16'd0, {6'd0, best_assignment});
    endtask

    // done must come at the expect_k-th falling edge from here
    task automatic await_done(input int n, input int expect_k);
        int k;
        bit seen;
        seen = 1'b0;
        k    = 0;
        while (!seen && k < expect_k + done_slack)
        begin
            @(negedge clk);
            k++;
            if (done)
            begin
                seen = 1'b1;
                checks++;
                assert (k == expect_k)
                else
                begin
                    protocol_errors++;
                    if (k < expect_k)
                        $display("done for data line %0d came %0d cycles early", n, expect_k - k);
                    else
                        $display("done for data line %0d came %0d cycles late", n, k - expect_k);
                end
            end
        end
        checks++;
        assert (seen)
        else
        begin
            protocol_errors++;
            $display("done for data line %0d never came", n);
        end
        if (seen)
            check_results(n);
    endtask

    //////////////////////////////////////////////////
    // stimulus

    task automatic write_clause(input int n);
        clause_t c;
        c.coef1        = fld[n][1][3:0];
        c.coef0        = fld[n][2][3:0];
        c.bias         = fld[n][3][3:0];
        c.bool_code[1] = fld[n][4][1:0];
        c.bool_code[0] = fld[n][5][1:0];
        @(posedge clk);
        clause_write <= 1'b1;
        clause_index <= fld[n][0][1:0];
        clause_data  <= c;
        @(posedge clk);
        clause_write <= 1'b0;
    endtask

    // raise start with the row's inputs, start stays high until end_start
    task automatic drive_search(input int n);
        assign_t a;
        a.bool_val = fld[n][0][1:0];
        a.int_val1 = fld[n][1][3:0];
        a.int_val0 = fld[n][2][3:0];
        @(posedge clk);
        current             <= a;
        clause_enable       <= fld[n][3][3:0];
        bool_propose_enable <= fld[n][4][1:0];
        int_propose_enable  <= fld[n][5][1:0];
        start               <= 1'b1;
    endtask

    task automatic end_start();
        @(posedge clk);
        start <= 1'b0;
    endtask

    task automatic run_tests();
        int n;
        n = 0;
        while (n < n_entries)
        begin
            if (kind[n] == "W")
            begin
                write_clause(n);
                n++;
            end
            else if (n + 1 < n_entries && kind[n+1] == "C")
            begin
                // back to back, two searches in flight
                drive_search(n);
                drive_search(n + 1);
                end_start();
                await_done(n, 1);
                await_done(n + 1, 1);
                n += 2;
            end
            else
            begin
                drive_search(n);
                end_start();
                await_done(n, 2);
                n++;
            end
        end
    endtask

    //////////////////////////////////////////////////
    // main sequence

    initial
    begin
        clk                 = 1'b0;
        rst_n               = 1'b0;
        clause_write        = 1'b0;
        clause_index        = '0;
        clause_data         = '0;
        clause_enable       = '0;
        current             = '0;
        bool_propose_enable = '0;
        int_propose_enable  = '0;
        start               = 1'b0;
        n_entries           = 0;
        checks              = 0;
        value_errors        = 0;
        protocol_errors     = 0;
        file_errors         = 0;
        load_tests();
        loaded = 1'b1;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        check_idle(5);
        run_tests();
        @(posedge clk);
        $display("checks %0d, value errors %0d, protocol errors %0d, file errors %0d",
                 checks, value_errors, protocol_errors, file_errors);
        if (value_errors + protocol_errors + file_errors == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

    // watchdog, budget grows with the number of data lines
    initial
    begin
        wait (loaded);
        repeat (n_entries * 10 + 50) @(posedge clk);
        $display("timeout, tests still running after %0d cycles", n_entries * 10 + 50);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: test/local_move_tests.txt
# W idx coef1 coef0 bias code1 code0    clause write, code = present,polarity
# S|C bool int1 int0 clause_en bool_pe int_pe g0 g1 g2 g3 best_gain best_bool best_int1 best_int0
# all fields hex, C goes out on the cycle right after the search before it
# zero clauses after reset, all satisfied
S 2 5 d f 0 0 0 0 0 0 4 2 5 d
S 2 5 d f 3 3 4 4 4 4 4 3 5 d
# formula: i0>=2|b0, i1<=3|!b1, i1+i0>=8|b1|!b0, 2*i1-3*i0>=0
W 0 0 1 e 0 3
W 1 f 0 3 2 0
W 2 1 1 8 3 2
W 3 2 d 0 1 1
# hand counted gains, int0 wins a tie with int1
S 0 1 1 f 3 3 2 2 3 3 3 0 1 2
S 0 1 1 f 0 0 0 0 0 0 2 0 1 1
# int1 wraps 7 to -8 and wins
S 3 7 a f 3 3 2 3 3 4 4 3 8 a
# int0 wraps 7 to -8
S 0 0 7 f 0 1 0 0 3 0 3 0 0 8
# masks, disabled proposals report 0 and never win
S 0 1 1 6 3 2 1 2 0 2 2 2 1 1
S 3 7 a f 3 1 2 3 3 0 3 1 7 a
S 3 7 a 8 0 0 0 0 0 0 1 3 7 a
# back to back searches
S 0 1 1 f 3 3 2 2 3 3 3 0 1 2
C 3 7 a f 3 3 2 3 3 4 4 3 8 a
S 3 7 a 8 0 0 0 0 0 0 1 3 7 a
C 0 1 1 6 3 2 1 2 0 2 2 2 1 1

// File: verilog/best_move_select.sv
`default_nettype none

// two stage best move selection
// stage one captures a search on start, stage two picks the winner and pulses done
// a new search may enter stage one while the previous one sits in stage two
module best_move_select
    import sat_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      start,            // one cycle pulse per search
    input  assign_t                   current,          // assignment before the move
    input  gain_t                     current_gain,     // count for current
    input  candidate_t [num_vars-1:0] candidates,       // proposals with valid flags
    input  gain_t [num_vars-1:0]      cand_gains,       // raw counts per proposal
    output gain_t [num_vars-1:0]      gains,            // 0 for a disabled proposal
    output gain_t                     best_gain,
    output assign_t                   best_assignment,
    output logic                      done              // results valid, one cycle
);

    //////////////////////////////////////////////////
    // stage one

    gain_t [num_vars-1:0]      masked_gains;  // disabled proposals forced to 0
    logic                      s1_valid;      // a search sits in stage one
    assign_t                   s1_current;
    gain_t                     s1_cur_gain;
    candidate_t [num_vars-1:0] s1_cands;
    gain_t [num_vars-1:0]      s1_gains;

    always_comb
    begin
        for (int i = 0; i < num_vars; i++)
        begin
            masked_gains[i] = candidates[i].valid ? cand_gains[i] : '0;
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            s1_valid <= 1'b0;
        else
            s1_valid <= start;
    end

    // payload only moves with start, held otherwise
    always_ff @(posedge clk)
    begin
        if (start)
        begin
            s1_current  <= current;
            s1_cur_gain <= current_gain;
            s1_cands    <= candidates;
            s1_gains    <= masked_gains;
        end
    end

    //////////////////////////////////////////////////
    // stage two, winner scan
    // highest count among enabled proposals, lowest index wins a tie

    gain_t   sel_gain;
    assign_t sel_assign;
    logic    found;     // at least one enabled proposal seen

    always_comb
    begin
        sel_gain   = s1_cur_gain;  // fallback when nothing enabled
        sel_assign = s1_current;
        found      = 1'b0;
        for (int i = 0; i < num_vars; i++)
        begin
            if (s1_cands[i].valid && (!found || (s1_gains[i] > sel_gain)))
            begin
                sel_gain   = s1_gains[i];  // strict > keeps the earlier index on a tie
                sel_assign = s1_cands[i].assignment;
                found      = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            gains           <= '0;
            best_gain       <= '0;
            best_assignment <= '0;
            done            <= 1'b0;
        end
        else
        begin
            done <= s1_valid;  // exactly one cycle per search
            if (s1_valid)
            begin
                gains           <= s1_gains;    // outputs hold until the next done
                best_gain       <= sel_gain;
                best_assignment <= sel_assign;
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/clause_eval.sv
`default_nettype none

// counts the enabled clauses satisfied by one assignment
// purely combinational, one instance per assignment under test
module clause_eval
    import sat_pkg::*;
(
    input  formula_t               formula,        // all clauses
    input  logic [num_clauses-1:0] clause_enable,  // masked clauses never count
    input  assign_t                assignment,     // values to test
    output gain_t                  sat_count       // satisfied and enabled clauses
);

    //////////////////////////////////////////////////
    // single clause check

    function automatic logic clause_sat(input clause_t c, input assign_t a);
        logic signed [sum_width-1:0] c0;
        logic signed [sum_width-1:0] c1;
        logic signed [sum_width-1:0] v0;
        logic signed [sum_width-1:0] v1;
        logic signed [sum_width-1:0] b;
        logic signed [sum_width-1:0] sum;
        logic                        bool_hit;
        begin
            // sign extend everything to sum_width before multiplying
            c0 = $signed(c.coef0);
            c1 = $signed(c.coef1);
            v0 = $signed(a.int_val0);
            v1 = $signed(a.int_val1);
            b  = $signed(c.bias);
            sum = (c0 * v0) + (c1 * v1) + b;  // worst case 64 + 64 + 7, fits

            // boolean side: present literal whose polarity matches the value
            bool_hit = 1'b0;
            for (int j = 0; j < num_bool_vars; j++)
            begin
                if (c.bool_code[j][1] && (a.bool_val[j] == c.bool_code[j][0]))
                begin
                    bool_hit = 1'b1;
                end
            end

            clause_sat = bool_hit || (sum >= 0);  // integer literal holds when sum >= 0
        end
    endfunction

    //////////////////////////////////////////////////
    // per clause results and count

    logic [num_clauses-1:0] sat_vec;  // raw satisfied flags, before mask

    always_comb
    begin
        for (int k = 0; k < num_clauses; k++)
        begin
            sat_vec[k] = clause_sat(formula[k], assignment);
        end
    end

    always_comb
    begin
        sat_count = '0;
        for (int k = 0; k < num_clauses; k++)
        begin
            // only enabled clauses add to the count
            sat_count = sat_count + gain_t'(sat_vec[k] & clause_enable[k]);
        end
    end

endmodule

`default_nettype wire

// File: verilog/clause_store.sv
`default_nettype none

// register file for the formula
// one clause overwritten per write strobe, all clauses readable in parallel
module clause_store
    import sat_pkg::*;
(
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           clause_write,  // write strobe, one clause per clock
    input  logic [$clog2(num_clauses)-1:0] clause_index,  // which clause to overwrite
    input  clause_t                        clause_data,   // new clause contents
    output formula_t                       formula        // all clauses, registered
);

    //////////////////////////////////////////////////
    // write decode

    logic [num_clauses-1:0] write_sel;  // one-hot clause select

    always_comb
    begin
        for (int k = 0; k < num_clauses; k++)
        begin
            write_sel[k] = clause_write && (clause_index == k[$clog2(num_clauses)-1:0]);
        end
    end

    //////////////////////////////////////////////////
    // clause registers
    // a zero clause has sum 0 and is therefore satisfied

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            formula <= '0;  // every clause cleared
        end
        else
        begin
            for (int k = 0; k < num_clauses; k++)
            begin
                if (write_sel[k])
                begin
                    formula[k] <= clause_data;  // visible one cycle after the strobe
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/local_move.sv
`default_nettype none

// local move step of the mixed boolean / integer search
// start at one edge, results with done two edges later
module local_move
    import sat_pkg::*;
(
    input  logic                           clk,
    input  logic                           rst_n,

    // formula loading
    input  logic                           clause_write,         // strobe
    input  logic [$clog2(num_clauses)-1:0] clause_index,
    input  clause_t                        clause_data,
    input  logic [num_clauses-1:0]         clause_enable,        // level, masks clause counts

    // search request
    input  assign_t                        current,              // level
    input  logic [num_bool_vars-1:0]       bool_propose_enable,  // level
    input  logic [num_int_vars-1:0]        int_propose_enable,   // level
    input  logic                           start,                // one cycle pulse

    // results
    output gain_t [num_vars-1:0]           gains,
    output gain_t                          best_gain,
    output assign_t                        best_assignment,
    output logic                           done                  // one cycle pulse
);

    //////////////////////////////////////////////////
    // internal nets

    formula_t                  formula;       // registered clauses
    candidate_t [num_vars-1:0] candidates;    // one proposal per variable
    gain_t                     current_gain;  // count before the move
    gain_t [num_vars-1:0]      cand_gains;    // count per proposal, unmasked

    //////////////////////////////////////////////////
    // formula storage

    clause_store u_clause_store (
        .clk          (clk),
        .rst_n        (rst_n),
        .clause_write (clause_write),
        .clause_index (clause_index),
        .clause_data  (clause_data),
        .formula      (formula)
    );

    //////////////////////////////////////////////////
    // proposals

    move_proposer u_move_proposer (
        .current             (current),
        .bool_propose_enable (bool_propose_enable),
        .int_propose_enable  (int_propose_enable),
        .candidates          (candidates)
    );

    //////////////////////////////////////////////////
    // evaluation, current plus one per proposal

    clause_eval u_eval_current (
        .formula       (formula),
        .clause_enable (clause_enable),
        .assignment    (current),
        .sat_count     (current_gain)
    );

    for (genvar i = 0; i < num_vars; i++)
    begin : g_eval_cand
        clause_eval u_eval_cand (
            .formula       (formula),
            .clause_enable (clause_enable),
            .assignment    (candidates[i].assignment),
            .sat_count     (cand_gains[i])
        );
    end

    //////////////////////////////////////////////////
    // selection, two register stages

    best_move_select u_best_move_select (
        .clk             (clk),
        .rst_n           (rst_n),
        .start           (start),
        .current         (current),
        .current_gain    (current_gain),
        .candidates      (candidates),
        .cand_gains      (cand_gains),
        .gains           (gains),
        .best_gain       (best_gain),
        .best_assignment (best_assignment),
        .done            (done)
    );

endmodule

`default_nettype wire

// File: verilog/move_proposer.sv
`default_nettype none

// one proposal per variable
// booleans flip, integers step up by one and wrap in two's complement
// candidate order: bool0, bool1, int0, int1
module move_proposer
    import sat_pkg::*;
(
    input  assign_t                  current,              // assignment before the move
    input  logic [num_bool_vars-1:0] bool_propose_enable,  // per boolean variable
    input  logic [num_int_vars-1:0]  int_propose_enable,   // per integer variable
    output candidate_t [num_vars-1:0] candidates           // all proposals
);

    localparam int int0_idx = num_bool_vars;      // first integer candidate
    localparam int int1_idx = num_bool_vars + 1;  // second integer candidate

    always_comb
    begin
        //////////////////////////////////////////////////
        // boolean flips

        for (int i = 0; i < num_bool_vars; i++)
        begin
            candidates[i].assignment             = current;              // start from current
            candidates[i].assignment.bool_val[i] = ~current.bool_val[i]; // flip only variable i
            candidates[i].valid                  = bool_propose_enable[i];
        end

        //////////////////////////////////////////////////
        // integer increments
        // 4 bit add, so 7 + 1 wraps to -8

        candidates[int0_idx].assignment          = current;
        candidates[int0_idx].assignment.int_val0 = current.int_val0 + int_width'(1);
        candidates[int0_idx].valid               = int_propose_enable[0];

        candidates[int1_idx].assignment          = current;
        candidates[int1_idx].assignment.int_val1 = current.int_val1 + int_width'(1);
        candidates[int1_idx].valid               = int_propose_enable[1];
    end

endmodule

`default_nettype wire

// File: verilog/sat_pkg.sv
`default_nettype none

package sat_pkg;

    //////////////////////////////////////////////////
    // formula size

    localparam int num_bool_vars = 2;                       // boolean variables in a formula
    localparam int num_int_vars  = 2;                       // integer variables in a formula
    localparam int num_vars      = num_bool_vars + num_int_vars; // one candidate move per variable
    localparam int num_clauses   = 4;                       // clauses in a formula

    // datapath widths
    localparam int int_width  = 4;   // integer value and coefficient, two's complement
    localparam int sum_width  = 10;  // widened so coef*value + coef*value + bias never overflows
    localparam int gain_width = 3;   // holds 0 .. num_clauses

    //////////////////////////////////////////////////
    // assignment of all variables

    typedef struct packed {
        logic [num_bool_vars-1:0]    bool_val;  // bit i is the value of boolean i
        logic signed [int_width-1:0] int_val1;  // integer variable 1
        logic signed [int_width-1:0] int_val0;  // integer variable 0
    } assign_t;                                 // 10 bits

    //////////////////////////////////////////////////
    // one clause
    // integer literal: coef1*int1 + coef0*int0 + bias >= 0
    // boolean code per variable: [1] literal present, [0] polarity (1 = positive)

    typedef struct packed {
        logic signed [int_width-1:0]   coef1;
        logic signed [int_width-1:0]   coef0;
        logic signed [int_width-1:0]   bias;
        logic [num_bool_vars-1:0][1:0] bool_code;
    } clause_t;                                 // 16 bits

    // whole formula, clause k at index k
    typedef clause_t [num_clauses-1:0] formula_t;

    // number of satisfied clauses
    typedef logic [gain_width-1:0] gain_t;

    // proposed move with its enable
    typedef struct packed {
        assign_t assignment;  // current assignment with one variable changed
        logic    valid;       // proposal enabled for this variable
    } candidate_t;            // 11 bits

endpackage

`default_nettype wire
